//--- verilog/ipod_params.svh
`ifndef IPOD_PARAMS_SVH
`define IPOD_PARAMS_SVH

//========================================
// Playback rate limits
//========================================

// Divisor change per speed button event
`define IPOD_SPEED_STEP 8

// Divisor range in 50 MHz cycles per sample
`define IPOD_MIN_DIVISOR 16
`define IPOD_MAX_DIVISOR 8192

//========================================
// Flash geometry
//========================================

// Word address width of the flash read port
`define IPOD_FLASH_ADDR_W 23

`endif

//--- verilog/ipod_pkg.sv
`default_nettype none

`include "ipod_params.svh"

package ipod_pkg;

  // Flash word address
  typedef logic [`IPOD_FLASH_ADDR_W-1:0] flash_addr_t;

  // One flash word, two 16-bit halves
  typedef logic [31:0] flash_word_t;

  // Audio sample, upper byte of a half word
  typedef logic [7:0] sample_t;

  // Sample period in clock cycles
  typedef logic [15:0] divisor_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

//--- verilog/flash_rd_if.sv
`default_nettype none
`timescale 1ns/1ps

// Single-read flash port, no waitrequest
interface flash_rd_if;

  logic                  read;
  ipod_pkg::flash_addr_t address;
  ipod_pkg::flash_word_t readdata;
  logic                  readdatavalid;

  // Player side issues reads
  modport reader (
    output read,
    output address,
    input  readdata,
    input  readdatavalid
  );

  // Top level side toward the flash pins
  modport host (
    input  read,
    input  address,
    output readdata,
    output readdatavalid
  );

endinterface

`default_nettype wire

//--- verilog/kbd_command_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module kbd_command_decoder (
  input  wire logic              CLK_50M,
  input  wire logic              arst_n,
  input  wire ipod_pkg::sample_t kbd_ascii,
  input  wire logic              kbd_valid,
  output logic                   paused,
  output logic                   forward,
  output logic                   restart
);

  // Command keys in both cases
  localparam ipod_pkg::sample_t KEY_E_UP = 8'h45;
  localparam ipod_pkg::sample_t KEY_E_LO = 8'h65;
  localparam ipod_pkg::sample_t KEY_D_UP = 8'h44;
  localparam ipod_pkg::sample_t KEY_D_LO = 8'h64;
  localparam ipod_pkg::sample_t KEY_F_UP = 8'h46;
  localparam ipod_pkg::sample_t KEY_F_LO = 8'h66;
  localparam ipod_pkg::sample_t KEY_B_UP = 8'h42;
  localparam ipod_pkg::sample_t KEY_B_LO = 8'h62;
  localparam ipod_pkg::sample_t KEY_R_UP = 8'h52;
  localparam ipod_pkg::sample_t KEY_R_LO = 8'h72;

  // Player comes up paused and playing forward
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      paused  <= 1'b1;
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      // Restart is a single-cycle pulse
      restart <= kbd_valid && (kbd_ascii == KEY_R_UP || kbd_ascii == KEY_R_LO);
      if (kbd_valid)
      begin
        case (kbd_ascii)
          KEY_E_UP, KEY_E_LO: paused  <= 1'b0;
          KEY_D_UP, KEY_D_LO: paused  <= 1'b1;
          KEY_F_UP, KEY_F_LO: forward <= 1'b1;
          KEY_B_UP, KEY_B_LO: forward <= 1'b0;
          default:
          begin
            // Anything else is ignored
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/speed_control.sv
`default_nettype none
`timescale 1ns/1ps

`include "ipod_params.svh"

module speed_control #(
  parameter ipod_pkg::divisor_t DEFAULT_DIVISOR = 16'd2268
) (
  input  wire logic          CLK_50M,
  input  wire logic          arst_n,
  input  wire logic          speed_up,
  input  wire logic          speed_down,
  input  wire logic          speed_reset,
  output ipod_pkg::divisor_t divisor
);

  localparam ipod_pkg::divisor_t STEP    = `IPOD_SPEED_STEP;
  localparam ipod_pkg::divisor_t MIN_DIV = `IPOD_MIN_DIVISOR;
  localparam ipod_pkg::divisor_t MAX_DIV = `IPOD_MAX_DIVISOR;

  logic at_floor;
  logic at_ceiling;

  // One more step would cross a limit
  assign at_floor   = (divisor < MIN_DIV + STEP);
  assign at_ceiling = (divisor > MAX_DIV - STEP);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      divisor <= DEFAULT_DIVISOR;
    end
    else if (speed_reset)
    begin
      // Reset event wins over up and down
      divisor <= DEFAULT_DIVISOR;
    end
    else if (speed_up)
    begin
      // Shorter period, faster playback
      divisor <= at_floor ? MIN_DIV : divisor - STEP;
    end
    else if (speed_down)
    begin
      divisor <= at_ceiling ? MAX_DIV : divisor + STEP;
    end
  end

endmodule

`default_nettype wire

//--- verilog/sample_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module sample_clock_gen (
  input  wire logic               CLK_50M,
  input  wire logic               arst_n,
  input  wire ipod_pkg::divisor_t divisor,
  input  wire logic               restart,
  output logic                    tick
);

  ipod_pkg::divisor_t count;

  // Counts divisor-1 down to 0, so one tick per divisor cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (restart)
    begin
      // Start a full period again
      count <= divisor - 1'b1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      // New divisor only takes hold on reload
      count <= divisor - 1'b1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/flash_reader.sv
`default_nettype none
`timescale 1ns/1ps

module flash_reader #(
  parameter ipod_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  wire logic         CLK_50M,
  input  wire logic         arst_n,
  input  wire logic         tick,
  input  wire logic         paused,
  input  wire logic         forward,
  input  wire logic         restart,
  flash_rd_if.reader        flash,
  output ipod_pkg::sample_t sample_data,
  output logic              sample_valid,
  output logic              song_end
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    HOLD
  } state_t;

  state_t                state;
  ipod_pkg::flash_addr_t addr;
  ipod_pkg::flash_addr_t next_addr;
  ipod_pkg::flash_word_t word_q;
  logic                  fwd_q;
  logic                  read_q;
  logic                  start_read;
  logic                  take_word;
  logic                  play_second;
  logic                  at_wrap;

  //========================================
  // Step conditions
  //========================================

  // Ticks in FETCH fall through and are lost
  assign start_read  = (state == IDLE) && tick && !paused && !restart;
  assign take_word   = (state == FETCH) && flash.readdatavalid && !restart;
  assign play_second = (state == HOLD) && tick && !paused && !restart;

  // Last word of the song in the current direction
  assign at_wrap = fwd_q ? (addr == LAST_ADDR) : (addr == '0);

  always_comb
  begin
    if (fwd_q)
      next_addr = at_wrap ? '0 : addr + 1'b1;
    else
      next_addr = at_wrap ? LAST_ADDR : addr - 1'b1;
  end

  assign flash.read    = read_q;
  assign flash.address = addr;

  //========================================
  // Control FSM
  //========================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= IDLE;
      addr         <= '0;
      fwd_q        <= 1'b1;
      read_q       <= 1'b0;
      sample_valid <= 1'b0;
      song_end     <= 1'b0;
    end
    else
    begin
      read_q       <= start_read;
      sample_valid <= take_word || play_second;
      // Flags the final sample of the song
      song_end     <= play_second && at_wrap;
      if (restart)
      begin
        state <= IDLE;
        addr  <= forward ? '0 : LAST_ADDR;
      end
      else
      begin
        case (state)
          IDLE:
          begin
            if (start_read)
            begin
              // Direction is fixed for both halves of this word
              state <= FETCH;
              fwd_q <= forward;
            end
          end
          FETCH:
          begin
            if (take_word)
              state <= HOLD;
          end
          HOLD:
          begin
            if (play_second)
            begin
              state <= IDLE;
              addr  <= next_addr;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  //========================================
  // Sample data path
  //========================================

  // Forward plays 15:8 then 31:24, backward the reverse
  always_ff @(posedge CLK_50M)
  begin
    if (take_word)
    begin
      word_q      <= flash.readdata;
      sample_data <= fwd_q ? flash.readdata[15:8] : flash.readdata[31:24];
    end
    else if (play_second)
    begin
      sample_data <= fwd_q ? word_q[31:24] : word_q[15:8];
    end
  end

endmodule

`default_nettype wire

//--- verilog/hex_display.sv
`default_nettype none
`timescale 1ns/1ps

module hex_display (
  input  wire ipod_pkg::divisor_t divisor,
  output ipod_pkg::seg7_t         hex0,
  output ipod_pkg::seg7_t         hex1,
  output ipod_pkg::seg7_t         hex2,
  output ipod_pkg::seg7_t         hex3,
  output ipod_pkg::seg7_t         hex4,
  output ipod_pkg::seg7_t         hex5
);

  logic [23:0] value;

  // Active-low font, segment a in bit 0
  function automatic ipod_pkg::seg7_t hex_font(input logic [3:0] nib);
    ipod_pkg::seg7_t seg;
    case (nib)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'hA:    seg = 7'b0001000;
      4'hB:    seg = 7'b0000011;
      4'hC:    seg = 7'b1000110;
      4'hD:    seg = 7'b0100001;
      4'hE:    seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // Top two digits always read 0
  assign value = {8'h00, divisor};

  assign hex0 = hex_font(value[3:0]);
  assign hex1 = hex_font(value[7:4]);
  assign hex2 = hex_font(value[11:8]);
  assign hex3 = hex_font(value[15:12]);
  assign hex4 = hex_font(value[19:16]);
  assign hex5 = hex_font(value[23:20]);

endmodule

`default_nettype wire

//--- verilog/ipod_player.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_player #(
  parameter ipod_pkg::divisor_t    DEFAULT_DIVISOR = 16'd2268,
  parameter ipod_pkg::flash_addr_t LAST_ADDR       = 23'h7FFFF
) (
  input  wire logic                  CLK_50M,
  input  wire logic                  arst_n,
  input  wire ipod_pkg::sample_t     kbd_ascii,
  input  wire logic                  kbd_valid,
  input  wire logic                  speed_up,
  input  wire logic                  speed_down,
  input  wire logic                  speed_reset,
  output logic                       flash_read,
  output ipod_pkg::flash_addr_t      flash_address,
  input  wire ipod_pkg::flash_word_t flash_readdata,
  input  wire logic                  flash_readdatavalid,
  output ipod_pkg::sample_t          sample_data,
  output logic                       sample_valid,
  output logic                       song_end,
  output ipod_pkg::seg7_t            hex0,
  output ipod_pkg::seg7_t            hex1,
  output ipod_pkg::seg7_t            hex2,
  output ipod_pkg::seg7_t            hex3,
  output ipod_pkg::seg7_t            hex4,
  output ipod_pkg::seg7_t            hex5
);

  logic               paused;
  logic               forward;
  logic               restart;
  logic               tick;
  ipod_pkg::divisor_t divisor;

  flash_rd_if u_flash_if ();

  //========================================
  // Flash pins
  //========================================

  assign flash_read              = u_flash_if.read;
  assign flash_address           = u_flash_if.address;
  assign u_flash_if.readdata      = flash_readdata;
  assign u_flash_if.readdatavalid = flash_readdatavalid;

  //========================================
  // Control and playback
  //========================================

  kbd_command_decoder u_kbd_command_decoder (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .paused    (paused),
    .forward   (forward),
    .restart   (restart)
  );

  speed_control #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR)
  ) u_speed_control (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divisor     (divisor)
  );

  sample_clock_gen u_sample_clock_gen (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .divisor (divisor),
    .restart (restart),
    .tick    (tick)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) u_flash_reader (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .paused       (paused),
    .forward      (forward),
    .restart      (restart),
    .flash        (u_flash_if.reader),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .song_end     (song_end)
  );

  hex_display u_hex_display (
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

`default_nettype wire

//--- tests/flash_model.sv
`default_nettype none
`timescale 1ns/1ps

// Flash responder, one read at a time, 1 to 8 cycles latency
module flash_model (
  input  wire logic                  CLK_50M,
  input  wire logic                  arst_n,
  input  wire logic                  read,
  input  wire ipod_pkg::flash_addr_t address,
  output ipod_pkg::flash_word_t      readdata,
  output logic                       readdatavalid
);

  localparam logic [7:0] LFSR_SEED = 8'd54;
  // Taps for x^8 + x^6 + x^5 + x^4 + 1
  localparam logic [7:0] LFSR_TAPS = 8'hB8;

  logic [7:0]            lfsr_state;
  logic [2:0]            lat_bits;
  logic [3:0]            remaining;
  logic                  pending;
  ipod_pkg::flash_addr_t addr_q;
  integer                i;

  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // Bytes a+0x40, a+0x30, a+0x20, a+0x10 from the top
  function automatic ipod_pkg::flash_word_t word_at(input ipod_pkg::flash_addr_t a);
    logic [7:0] b;
    // Upper address bits fold in, so aliased words differ
    b = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};
    return {b + 8'h40, b + 8'h30, b + 8'h20, b + 8'h10};
  endfunction

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lfsr_state     = LFSR_SEED;
      pending       <= 1'b0;
      remaining     <= '0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (read)
      begin
        // One LFSR step per latency bit
        lat_bits = '0;
        for (i = 0; i < 3; i++)
        begin
          lat_bits[i] = lfsr_state[0];
          lfsr_state  = lfsr_next(lfsr_state);
        end
        pending   <= 1'b1;
        remaining <= {1'b0, lat_bits} + 4'd1;
        addr_q    <= address;
      end
      else if (pending)
      begin
        if (remaining == 4'd1)
        begin
          pending       <= 1'b0;
          readdatavalid <= 1'b1;
          readdata      <= word_at(addr_q);
        end
        else
        begin
          remaining <= remaining - 4'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_ipod_player.sv
`default_nettype none
`timescale 1ns/1ps

`include "ipod_params.svh"

module tb_ipod_player;

  localparam int CLK_PERIOD  = 20;
  localparam int DIVISOR     = 40;
  localparam int LAST_ADDR   = 5;
  localparam int SPEED_STEP  = `IPOD_SPEED_STEP;
  localparam int MIN_DIVISOR = `IPOD_MIN_DIVISOR;
  localparam int MAX_DIVISOR = `IPOD_MAX_DIVISOR;

  // Speed events in the sweep, two cycles each
  localparam int SPEED_PULSES = (MAX_DIVISOR - DIVISOR) / SPEED_STEP
                                + (MAX_DIVISOR - MIN_DIVISOR) / SPEED_STEP + 7;

  // Test lengths in sample ticks
  localparam int RESET_TICKS    = 6;
  localparam int FORWARD_TICKS  = 16;
  localparam int BACKWARD_TICKS = 20;
  localparam int PAUSE_TICKS    = 12;
  localparam int SPEED_TICKS    = (2 * SPEED_PULSES + 2 * DIVISOR) / DIVISOR + 2;
  localparam int TIMEOUT_CYCLES = (RESET_TICKS + FORWARD_TICKS + BACKWARD_TICKS
                                   + PAUSE_TICKS + SPEED_TICKS) * DIVISOR * 2;
  // One sample per tick plus the flash latency
  localparam int SAMPLE_WAIT    = 2 * DIVISOR;

  logic                  CLK_50M;
  logic                  arst_n;
  ipod_pkg::sample_t     kbd_ascii;
  logic                  kbd_valid;
  logic                  speed_up;
  logic                  speed_down;
  logic                  speed_reset;
  logic                  flash_read;
  ipod_pkg::flash_addr_t flash_address;
  ipod_pkg::flash_word_t flash_readdata;
  logic                  flash_readdatavalid;
  ipod_pkg::sample_t     sample_data;
  logic                  sample_valid;
  logic                  song_end;
  ipod_pkg::seg7_t       hex0;
  ipod_pkg::seg7_t       hex1;
  ipod_pkg::seg7_t       hex2;
  ipod_pkg::seg7_t       hex3;
  ipod_pkg::seg7_t       hex4;
  ipod_pkg::seg7_t       hex5;

  // Received samples as {song_end, data}
  logic [8:0] sample_q[$];
  logic       read_pending = 1'b0;
  logic       rdv_d = 1'b0;
  int         error_count = 0;
  int         monitor_errors = 0;
  int         read_count = 0;
  int         response_count = 0;
  int         sample_count = 0;
  int         cycle_count = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         test_start_errors = 0;
  int         reads_before;
  int         samples_before;

  // Expected playback position and divisor
  int         exp_addr;
  logic       exp_half;
  logic       exp_fwd;
  int         exp_div;

  ipod_player #(
    .DEFAULT_DIVISOR (DIVISOR),
    .LAST_ADDR       (LAST_ADDR)
  ) u_ipod_player (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_data         (sample_data),
    .sample_valid        (sample_valid),
    .song_end            (song_end),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  flash_model u_flash_model (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .read          (flash_read),
    .address       (flash_address),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  //========================================
  // Checks and helpers
  //========================================

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // Standard active-low font with segment a in bit 0
  function automatic ipod_pkg::seg7_t seg_pattern(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  task automatic check_display(input int value);
    logic [23:0] v;
    v = value;
    assert ({hex5, hex4, hex3, hex2, hex1, hex0} ==
            {seg_pattern(v[23:20]), seg_pattern(v[19:16]), seg_pattern(v[15:12]),
             seg_pattern(v[11:8]), seg_pattern(v[7:4]), seg_pattern(v[3:0])})
    else
      report_mismatch($sformatf("hex digits do not show divisor %0d", value));
  endtask

  // Half words carry a+0x20 low and a+0x40 high in their upper bytes
  function automatic ipod_pkg::sample_t expected_sample(input logic [7:0] a,
                                                        input logic upper);
    return upper ? a + 8'h40 : a + 8'h20;
  endfunction

  task automatic advance_cursor();
    if (!exp_half)
      exp_half = 1'b1;
    else
    begin
      exp_half = 1'b0;
      if (exp_fwd)
        exp_addr = (exp_addr == LAST_ADDR) ? 0 : exp_addr + 1;
      else
        exp_addr = (exp_addr == 0) ? LAST_ADDR : exp_addr - 1;
    end
  endtask

  task automatic check_next_sample();
    int                waited;
    logic [8:0]        got;
    ipod_pkg::sample_t want;
    logic              want_end;
    waited   = 0;
    want     = expected_sample(exp_addr[7:0], exp_fwd ? exp_half : !exp_half);
    want_end = exp_half && (exp_fwd ? exp_addr == LAST_ADDR : exp_addr == 0);
    while (sample_q.size() == 0 && waited < SAMPLE_WAIT)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    if (sample_q.size() == 0)
    begin
      $display("No sample arrived within %0d cycles at %0t ns", SAMPLE_WAIT, $time);
      error_count++;
    end
    else
    begin
      got = sample_q.pop_front();
      assert (got[7:0] == want)
      else
        report_mismatch($sformatf("sample 0x%02h, expected 0x%02h from address %0d",
                                  got[7:0], want, exp_addr));
      assert (got[8] == want_end)
      else
        report_mismatch($sformatf("song_end %0b, expected %0b at address %0d",
                                  got[8], want_end, exp_addr));
    end
    advance_cursor();
  endtask

  task automatic send_key(input ipod_pkg::sample_t code);
    @(negedge CLK_50M);
    kbd_ascii = code;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic rst);
    @(negedge CLK_50M);
    speed_up    = up;
    speed_down  = down;
    speed_reset = rst;
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    check_display(exp_div);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_start_errors)
      $display("Test %0d %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  //========================================
  // Bus monitor
  //========================================

  always @(posedge CLK_50M)
  begin
    if (!arst_n)
    begin
      read_pending <= 1'b0;
      rdv_d        <= 1'b0;
    end
    else
    begin
      assert (!(flash_read && read_pending))
      else
      begin
        report_mismatch("flash_read pulsed while a read was pending");
        monitor_errors++;
      end
      assert (!rdv_d || sample_valid)
      else
      begin
        report_mismatch("no sample_valid one cycle after readdatavalid");
        monitor_errors++;
      end
      assert (!song_end || sample_valid)
      else
        report_mismatch("song_end without sample_valid");
      if (flash_read)
      begin
        read_pending <= 1'b1;
        read_count++;
      end
      else if (flash_readdatavalid)
        read_pending <= 1'b0;
      if (flash_readdatavalid)
        response_count++;
      rdv_d <= flash_readdatavalid;
      if (sample_valid)
      begin
        sample_q.push_back({song_end, sample_data});
        sample_count++;
      end
    end
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge CLK_50M);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles before the tests finished", cycle_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //========================================
  // Test sequence
  //========================================

  initial
  begin
    arst_n      = 1'b0;
    kbd_ascii   = '0;
    kbd_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_div     = DIVISOR;
    repeat (3) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;

    // Quiet and paused out of reset
    @(negedge CLK_50M);
    assert (!flash_read && !sample_valid && !song_end)
    else
      report_mismatch("outputs not low after reset");
    check_display(DIVISOR);
    repeat (4 * DIVISOR) @(negedge CLK_50M);
    assert (sample_count == 0 && read_count == 0)
    else
      report_mismatch("flash activity before the play command");
    finish_test("reset state");

    // Forward through the song and past the wrap
    exp_addr = 0;
    exp_half = 1'b0;
    exp_fwd  = 1'b1;
    send_key("E");
    repeat (2 * (LAST_ADDR + 1) + 1) check_next_sample();
    finish_test("forward playback");

    // Stop, drain, turn around and restart from the end
    send_key("d");
    repeat (SAMPLE_WAIT) @(negedge CLK_50M);
    sample_q.delete();
    send_key("b");
    send_key("R");
    exp_addr = LAST_ADDR;
    exp_half = 1'b0;
    exp_fwd  = 1'b0;
    send_key("e");
    repeat (2 * (LAST_ADDR + 1) + 1) check_next_sample();
    finish_test("backward playback and restart");

    check_next_sample();
    send_key("D");
    @(negedge CLK_50M);
    reads_before   = read_count;
    samples_before = sample_count;
    repeat (4 * DIVISOR) @(negedge CLK_50M);
    assert (read_count == reads_before && sample_count == samples_before)
    else
      report_mismatch("flash read or sample while paused");
    send_key("E");
    repeat (2) check_next_sample();
    // Back to forward on a word boundary
    send_key("F");
    exp_fwd = 1'b1;
    repeat (2) check_next_sample();
    finish_test("pause");

    // Player paused so the divisor sweep cannot disturb playback
    send_key("D");
    repeat (SAMPLE_WAIT) @(negedge CLK_50M);
    sample_q.delete();
    repeat ((MAX_DIVISOR - DIVISOR) / SPEED_STEP + 2)
    begin
      exp_div = (exp_div + SPEED_STEP > MAX_DIVISOR) ? MAX_DIVISOR : exp_div + SPEED_STEP;
      pulse_speed(1'b0, 1'b1, 1'b0);
    end
    repeat ((MAX_DIVISOR - MIN_DIVISOR) / SPEED_STEP + 2)
    begin
      exp_div = (exp_div - SPEED_STEP < MIN_DIVISOR) ? MIN_DIVISOR : exp_div - SPEED_STEP;
      pulse_speed(1'b1, 1'b0, 1'b0);
    end
    exp_div = DIVISOR;
    pulse_speed(1'b1, 1'b0, 1'b1);
    exp_div = DIVISOR + SPEED_STEP;
    pulse_speed(1'b0, 1'b1, 1'b0);
    exp_div = DIVISOR;
    pulse_speed(1'b0, 1'b1, 1'b1);
    finish_test("speed events");

    assert (monitor_errors == 0)
    else
      report_mismatch($sformatf("%0d flash handshake violations", monitor_errors));
    assert (read_count > 0 && read_count == response_count)
    else
      report_mismatch($sformatf("%0d reads but %0d responses", read_count, response_count));
    finish_test("single outstanding read");

    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/ipod_pkg.sv
verilog/flash_rd_if.sv
verilog/kbd_command_decoder.sv
verilog/speed_control.sv
verilog/sample_clock_gen.sv
verilog/flash_reader.sv
verilog/hex_display.sv
verilog/ipod_player.sv
tests/flash_model.sv
tests/tb_ipod_player.sv

//--- Bender.yml
package:
  name: ipod_player

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ipod_pkg.sv
      - verilog/flash_rd_if.sv
      - verilog/kbd_command_decoder.sv
      - verilog/speed_control.sv
      - verilog/sample_clock_gen.sv
      - verilog/flash_reader.sv
      - verilog/hex_display.sv
      - verilog/ipod_player.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/flash_model.sv
      - tests/tb_ipod_player.sv
